// File: rtl/soc_event_macros.svh
/* SoC event path constants
   Line counts, widths, FIFO depth and the fabric-controller event bit map */

`ifndef SOC_EVENT_MACROS_SVH
`define SOC_EVENT_MACROS_SVH

// Arbitrated event lines
`define SEV_NUM_PER_EVENTS   16
`define SEV_NUM_HWPE_EVENTS  2
`define SEV_NUM_LINES        18

// Event stream
`define SEV_EVENT_WIDTH      8
`define SEV_FIFO_DEPTH       4

// Fabric-controller event vector, unlisted bits stay 0
`define SEV_FC_EVENTS_WIDTH  32
`define SEV_FC_BIT_DMA_EVT   8
`define SEV_FC_BIT_DMA_IRQ   9
`define SEV_FC_BIT_PF_EVT    12
`define SEV_FC_BIT_REF_EDGE  14
`define SEV_FC_BIT_ERR       29
`define SEV_FC_BIT_HWPE0     30
`define SEV_FC_BIT_HWPE1     31

`endif

// File: rtl/soc_event_pkg.sv
/* SoC event path types
   Event numbers, line vectors and the registered input sample */

`include "soc_event_macros.svh"

package soc_event_pkg;

    // Number carried on the event stream
    typedef logic [`SEV_EVENT_WIDTH-1:0] event_id_t;

    // One bit per arbitrated line, 0..15 generic, 16..17 accelerator
    typedef logic [`SEV_NUM_LINES-1:0] event_lines_t;

    typedef logic [`SEV_FC_EVENTS_WIDTH-1:0] fc_events_t;

    typedef logic [`SEV_NUM_PER_EVENTS-1:0] per_events_t;

    // All event inputs as seen after the first register stage
    typedef struct packed {
        per_events_t                     per;
        logic [`SEV_NUM_HWPE_EVENTS-1:0] hwpe;
        logic                            dma_pe_evt;
        logic                            dma_pe_irq;
        logic                            pf_evt;
        logic                            ref_edge;
    } event_sample_t;

endpackage

// File: rtl/soc_event_sample.sv
/* Event input stage
   Turns slow clock changes into edge pulses and registers all event inputs */

`timescale 1ns/1ps

module soc_event_sample (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        slow_clk_i,
    input  soc_event_pkg::per_events_t  per_events_i,
    input  logic [1:0]                  fc_hwpe_events_i,
    input  logic                        dma_pe_evt_i,
    input  logic                        dma_pe_irq_i,
    input  logic                        pf_evt_i,
    output soc_event_pkg::event_sample_t sample_o
);

    // Two flop synchronizer plus a delayed copy for edge detection
    logic [1:0] ref_sync_q;
    logic       ref_prev_q;
    logic       ref_edge;

    soc_event_pkg::event_sample_t sample_q;

    // Rise or fall of the reference clock
    assign ref_edge = ref_sync_q[1] ^ ref_prev_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ref_sync_q <= '0;
            ref_prev_q <= 1'b0;
            sample_q   <= '0;
        end else begin
            ref_sync_q          <= {ref_sync_q[0], slow_clk_i};
            ref_prev_q          <= ref_sync_q[1];
            sample_q.per        <= per_events_i;
            sample_q.hwpe       <= fc_hwpe_events_i;
            sample_q.dma_pe_evt <= dma_pe_evt_i;
            sample_q.dma_pe_irq <= dma_pe_irq_i;
            sample_q.pf_evt     <= pf_evt_i;
            sample_q.ref_edge   <= ref_edge;
        end
    end

    assign sample_o = sample_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Reference clock is slow, so each change gives an isolated pulse
    a_ref_edge_single : assert property (
        @(posedge clk_i) disable iff (rst_i)
        sample_q.ref_edge |=> !sample_q.ref_edge
    );

endmodule

// File: rtl/event_pending.sv
/* Pending event stage
   Holds line pulses until granted, flags overruns and builds fc_events_o */

`timescale 1ns/1ps

`include "soc_event_macros.svh"

module event_pending (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  soc_event_pkg::event_sample_t sample_i,
    input  soc_event_pkg::event_lines_t  grant_i,
    output soc_event_pkg::event_lines_t  pending_o,
    output soc_event_pkg::fc_events_t    fc_events_o
);

    soc_event_pkg::event_lines_t lines;
    soc_event_pkg::event_lines_t pending_q;
    soc_event_pkg::fc_events_t   fc_events_d;
    soc_event_pkg::fc_events_t   fc_events_q;
    logic                        overrun;

    // Generic lines first, accelerator lines on top
    assign lines = {sample_i.hwpe, sample_i.per};

    // A repeat on a line still waiting is merged, so report it
    assign overrun = |(lines & pending_q & ~grant_i);

    ////////////////////////////////////////////////////////////////////////////
    // Fabric-controller event vector
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fc_events_d = '0;
        fc_events_d[`SEV_FC_BIT_DMA_EVT]  = sample_i.dma_pe_evt;
        fc_events_d[`SEV_FC_BIT_DMA_IRQ]  = sample_i.dma_pe_irq;
        fc_events_d[`SEV_FC_BIT_PF_EVT]   = sample_i.pf_evt;
        fc_events_d[`SEV_FC_BIT_REF_EDGE] = sample_i.ref_edge;
        fc_events_d[`SEV_FC_BIT_ERR]      = overrun;
        fc_events_d[`SEV_FC_BIT_HWPE0]    = sample_i.hwpe[0];
        fc_events_d[`SEV_FC_BIT_HWPE1]    = sample_i.hwpe[1];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q   <= '0;
            fc_events_q <= '0;
        end else begin
            // Grant clears, a new pulse on the same edge sets again
            pending_q   <= (pending_q & ~grant_i) | lines;
            fc_events_q <= fc_events_d;
        end
    end

    assign pending_o   = pending_q;
    assign fc_events_o = fc_events_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Arbiter only serves lines that are still waiting
    a_grant_pending : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (grant_i & ~pending_q) == '0
    );

endmodule

// File: rtl/event_arbiter.sv
/* Round-robin event arbiter
   Picks one pending line per cycle and pushes its number into the FIFO */

`timescale 1ns/1ps

`include "soc_event_macros.svh"

module event_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  soc_event_pkg::event_lines_t pending_i,
    input  logic                        full_i,
    output soc_event_pkg::event_lines_t grant_o,
    output logic                        push_o,
    output soc_event_pkg::event_id_t    push_id_o
);

    localparam int NumLines = `SEV_NUM_LINES;
    localparam int PtrW     = $clog2(NumLines);

    logic [PtrW-1:0]             ptr_q;
    logic [PtrW-1:0]             ptr_d;
    soc_event_pkg::event_lines_t cand;
    soc_event_pkg::event_lines_t grant_d;
    soc_event_pkg::event_lines_t grant_q;
    soc_event_pkg::event_id_t    id_d;
    soc_event_pkg::event_id_t    id_q;
    logic                        found;
    logic                        push_q;

    // Line granted last cycle is cleared in the pending stage on this edge
    assign cand = pending_i & ~grant_q;

    // Search starts at the pointer and wraps past the last line
    always_comb begin
        int idx;
        grant_d = '0;
        id_d    = '0;
        ptr_d   = ptr_q;
        found   = 1'b0;
        for (int i = 0; i < NumLines; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= NumLines) begin
                idx = idx - NumLines;
            end
            if (!found && !full_i && cand[idx]) begin
                found        = 1'b1;
                grant_d[idx] = 1'b1;
                id_d         = soc_event_pkg::event_id_t'(idx);
                ptr_d        = (idx == NumLines - 1) ? '0 : PtrW'(idx + 1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q   <= '0;
            grant_q <= '0;
            push_q  <= 1'b0;
        end else begin
            ptr_q   <= ptr_d;
            grant_q <= grant_d;
            push_q  <= found;
        end
    end

    always_ff @(posedge clk_i) begin
        id_q <= id_d;
    end

    assign grant_o   = grant_q;
    assign push_o    = push_q;
    assign push_id_o = id_q;

    // One line at most, and a push goes with every grant
    a_grant_onehot : assert property (
        @(posedge clk_i) disable iff (rst_i)
        $onehot0(grant_o) && (push_o == |grant_o)
    );

endmodule

// File: rtl/event_fifo.sv
/* Event number FIFO
   Circular buffer that feeds the fabric-controller valid/ready event stream */

`timescale 1ns/1ps

`include "soc_event_macros.svh"

module event_fifo (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     push_i,
    input  soc_event_pkg::event_id_t push_id_i,
    input  logic                     fc_event_ready_i,
    output logic                     full_o,
    output logic                     fc_event_valid_o,
    output soc_event_pkg::event_id_t fc_event_data_o
);

    localparam int Depth = `SEV_FIFO_DEPTH;
    localparam int PtrW  = $clog2(Depth);
    localparam int CntW  = $clog2(Depth + 1);

    soc_event_pkg::event_id_t mem_q [Depth];
    logic [PtrW-1:0]          wr_ptr_q;
    logic [PtrW-1:0]          rd_ptr_q;
    logic [CntW-1:0]          count_q;
    logic                     pop;

    assign fc_event_valid_o = (count_q != '0);
    assign fc_event_data_o  = mem_q[rd_ptr_q];
    assign pop              = fc_event_valid_o && fc_event_ready_i;

    // Push already on its way from the arbiter takes a slot too
    assign full_o = (int'(count_q) + int'(push_i)) >= Depth;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

    // Arbiter back-pressure keeps every push away from a full buffer
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (rst_i)
        push_i |-> (count_q < CntW'(Depth))
    );

endmodule

// File: rtl/soc_event_unit.sv
/* SoC event unit
   Sample, pending, arbiter and FIFO stages of the fabric-controller event path */

`timescale 1ns/1ps

module soc_event_unit (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       slow_clk_i,
    input  soc_event_pkg::per_events_t per_events_i,
    input  logic [1:0]                 fc_hwpe_events_i,
    input  logic                       dma_pe_evt_i,
    input  logic                       dma_pe_irq_i,
    input  logic                       pf_evt_i,
    input  logic                       fc_event_ready_i,
    output soc_event_pkg::fc_events_t  fc_events_o,
    output logic                       fc_event_valid_o,
    output soc_event_pkg::event_id_t   fc_event_data_o
);

    soc_event_pkg::event_sample_t s_sample;
    soc_event_pkg::event_lines_t  s_pending;
    soc_event_pkg::event_lines_t  s_grant;
    soc_event_pkg::event_id_t     s_push_id;
    logic                         s_push;
    logic                         s_full;

    soc_event_sample i_sample (
        .clk_i            ( clk_i            ),
        .rst_i            ( rst_i            ),
        .slow_clk_i       ( slow_clk_i       ),
        .per_events_i     ( per_events_i     ),
        .fc_hwpe_events_i ( fc_hwpe_events_i ),
        .dma_pe_evt_i     ( dma_pe_evt_i     ),
        .dma_pe_irq_i     ( dma_pe_irq_i     ),
        .pf_evt_i         ( pf_evt_i         ),
        .sample_o         ( s_sample         )
    );

    event_pending i_pending (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .sample_i    ( s_sample    ),
        .grant_i     ( s_grant     ),
        .pending_o   ( s_pending   ),
        .fc_events_o ( fc_events_o )
    );

    event_arbiter i_arbiter (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .pending_i ( s_pending ),
        .full_i    ( s_full    ),
        .grant_o   ( s_grant   ),
        .push_o    ( s_push    ),
        .push_id_o ( s_push_id )
    );

    event_fifo i_fifo (
        .clk_i            ( clk_i            ),
        .rst_i            ( rst_i            ),
        .push_i           ( s_push           ),
        .push_id_i        ( s_push_id        ),
        .fc_event_ready_i ( fc_event_ready_i ),
        .full_o           ( s_full           ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  )
    );

endmodule

// File: dv/tb_soc_event_unit.sv
/* SoC event unit testbench
   Directed tests of the event vector, line arbitration and stream back-pressure */

`timescale 1ns/1ps

`include "soc_event_macros.svh"

module tb_soc_event_unit;

    localparam int NumVectors = 16;
    // About 12 cycles per vector, 20 for the slow clock, under 40 per stream test
    localparam int MaxCycles  = 2000;

    logic        clk = 1'b0;
    logic        rst;
    logic        slow_clk;
    logic [15:0] per_events;
    logic [1:0]  fc_hwpe_events;
    logic        dma_pe_evt;
    logic        dma_pe_irq;
    logic        pf_evt;
    logic        fc_event_ready;
    logic [31:0] fc_events;
    logic        fc_event_valid;
    logic [7:0]  fc_event_data;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    integer      seed   = 32'hf2ef_c5ca;
    logic [7:0]  got_q [$];

    soc_event_unit DUT (
        .clk_i            ( clk            ),
        .rst_i            ( rst            ),
        .slow_clk_i       ( slow_clk       ),
        .per_events_i     ( per_events     ),
        .fc_hwpe_events_i ( fc_hwpe_events ),
        .dma_pe_evt_i     ( dma_pe_evt     ),
        .dma_pe_irq_i     ( dma_pe_irq     ),
        .pf_evt_i         ( pf_evt         ),
        .fc_event_ready_i ( fc_event_ready ),
        .fc_events_o      ( fc_events      ),
        .fc_event_valid_o ( fc_event_valid ),
        .fc_event_data_o  ( fc_event_data  )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Run stopped after %0d cycles, the tests did not complete", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Every transfer on the event stream
    always @(posedge clk) begin
        if (!rst && fc_event_valid && fc_event_ready) begin
            got_q.push_back(fc_event_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic drive_lines(input logic [17:0] lines);
        per_events     = lines[15:0];
        fc_hwpe_events = lines[17:16];
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        got_q.delete();
    endtask

    task automatic wait_items(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (got_q.size() < n) begin
            errors++;
            $display("Only %0d of %0d event numbers arrived on the stream", got_q.size(), n);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (fc_event_valid && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (fc_event_valid) begin
            errors++;
            $display("Event stream stayed valid after all numbers were taken");
        end
    endtask

    // From pointer 0, lines that are all pending at once come out in rising order
    task automatic check_order(input logic [17:0] lines);
        int k;
        k = 0;
        check_value("event count", got_q.size(), $countones(lines));
        for (int i = 0; i < 18; i++) begin
            if (lines[i] && k < got_q.size()) begin
                check_value("fc_event_data_o", got_q[k], i);
                k++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        apply_reset();
        check_value("fc_event_valid_o", fc_event_valid, 1'b0);
        check_value("fc_events_o", fc_events, '0);
    endtask

    task automatic test_direct_events();
        logic [4:0]  direct;
        logic [31:0] expected;
        int          base;
        int          seen;
        int          first;
        for (int v = 0; v < NumVectors; v++) begin
            direct         = 5'($random(seed));
            base           = got_q.size();
            dma_pe_evt     = direct[0];
            dma_pe_irq     = direct[1];
            pf_evt         = direct[2];
            fc_hwpe_events = direct[4:3];
            expected                       = '0;
            expected[`SEV_FC_BIT_DMA_EVT]  = direct[0];
            expected[`SEV_FC_BIT_DMA_IRQ]  = direct[1];
            expected[`SEV_FC_BIT_PF_EVT]   = direct[2];
            expected[`SEV_FC_BIT_HWPE0]    = direct[3];
            expected[`SEV_FC_BIT_HWPE1]    = direct[4];
            @(negedge clk);
            {fc_hwpe_events, pf_evt, dma_pe_irq, dma_pe_evt} = '0;
            @(negedge clk);
            check_value("fc_events_o", fc_events, expected);
            @(negedge clk);
            check_value("fc_events_o", fc_events, '0);
            // Accelerator pulses also travel down the stream
            wait_items(base + $countones(direct[4:3]));
            wait_idle();
        end
        for (int t = 0; t < 2; t++) begin
            slow_clk = ~slow_clk;
            seen     = 0;
            first    = 0;
            for (int c = 1; c <= 8; c++) begin
                @(negedge clk);
                if (fc_events[`SEV_FC_BIT_REF_EDGE]) begin
                    seen++;
                    if (first == 0) begin
                        first = c;
                    end
                end
            end
            check_value("ref_edge pulse count", seen, 1);
            if (first > 4) begin
                errors++;
                $display("Reference edge pulse came %0d cycles after the toggle", first);
            end
        end
    endtask

    task automatic test_single_line();
        int line;
        apply_reset();
        fc_event_ready = 1'b1;
        line           = {$random(seed)} % 18;
        drive_lines(18'(1) << line);
        @(negedge clk);
        drive_lines('0);
        wait_items(1);
        wait_idle();
        check_order(18'(1) << line);
    endtask

    task automatic test_round_robin();
        apply_reset();
        fc_event_ready = 1'b1;
        // Lines 3, 7 and 17
        drive_lines(18'h2_0088);
        @(negedge clk);
        drive_lines('0);
        wait_items(3);
        wait_idle();
        check_order(18'h2_0088);
    endtask

    task automatic test_back_pressure();
        logic [17:0] lines;
        int          idx;
        int          first;
        int          last;
        apply_reset();
        fc_event_ready = 1'b0;
        lines          = '0;
        first          = -1;
        last           = 0;
        while ($countones(lines) < 6) begin
            idx        = {$random(seed)} % 18;
            lines[idx] = 1'b1;
        end
        for (int i = 0; i < 18; i++) begin
            if (lines[i]) begin
                last = i;
                if (first < 0) begin
                    first = i;
                end
            end
        end
        drive_lines(lines);
        @(negedge clk);
        drive_lines('0);
        // One grant per cycle fills the four FIFO slots, the top two lines wait
        repeat (5) @(negedge clk);
        check_value("fc_event_valid_o", fc_event_valid, 1'b1);
        check_value("fc_event_data_o", fc_event_data, first);
        drive_lines(18'(1) << last);
        @(negedge clk);
        drive_lines('0);
        @(negedge clk);
        check_value("fc_events_o[29]", fc_events[`SEV_FC_BIT_ERR], 1'b1);
        @(negedge clk);
        check_value("fc_events_o[29]", fc_events[`SEV_FC_BIT_ERR], 1'b0);
        check_value("fc_event_data_o", fc_event_data, first);
        fc_event_ready = 1'b1;
        wait_items(6);
        wait_idle();
        check_order(lines);
    endtask

    initial begin
        rst            = 1'b1;
        slow_clk       = 1'b0;
        per_events     = '0;
        fc_hwpe_events = '0;
        dma_pe_evt     = 1'b0;
        dma_pe_irq     = 1'b0;
        pf_evt         = 1'b0;
        fc_event_ready = 1'b1;
        test_reset_values();
        test_direct_events();
        test_single_line();
        test_round_robin();
        test_back_pressure();
        $display("Finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/soc_event_pkg.sv
rtl/soc_event_sample.sv
rtl/event_pending.sv
rtl/event_arbiter.sv
rtl/event_fifo.sv
rtl/soc_event_unit.sv
dv/tb_soc_event_unit.sv

// File: Bender.yml
package:
  name: soc_event_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_event_pkg.sv
      - rtl/soc_event_sample.sv
      - rtl/event_pending.sv
      - rtl/event_arbiter.sv
      - rtl/event_fifo.sv
      - rtl/soc_event_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_soc_event_unit.sv
